//--- qla_reg_core.f
+incdir+src
src/qla_pkg.sv
src/reg_bus_merge.sv
src/hub_scratch.sv
src/axis_cmd_regs.sv
src/safety_check.sv
src/board_regs.sv
src/reg_read_router.sv
src/qla_reg_core.sv
verification/qla_reg_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= qla_reg_core_tb
RTL_TOP   ?= qla_reg_core
FILELIST  ?= qla_reg_core.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall -Isrc src/qla_pkg.sv src/reg_bus_merge.sv \
		src/hub_scratch.sv src/axis_cmd_regs.sv src/safety_check.sv src/board_regs.sv \
		src/reg_read_router.sv src/qla_reg_core.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/qla_reg_core_tb.sv
`timescale 1ns/1ps
`include "qla_consts.svh"

module qla_reg_core_tb;

    localparam int         MAX_STEPS    = 128;
    localparam int         RESET_CYCLES = 8;
    localparam int         OP_WR        = 0;
    localparam int         OP_RD        = 1;
    localparam int         OP_FB        = 2;     // drive one feedback current
    localparam int         OP_IDLE      = 3;
    localparam int         OP_CHK       = 4;     // cur_cmd, pwr and amp outputs
    localparam logic [3:0] WENID_VAL    = 4'ha;  // board id reads back as 5

    logic                                     sysclk = 1'b0;
    logic                                     rst_n;
    qla_pkg::reg_addr_t                       fw_reg_raddr;
    qla_pkg::reg_addr_t                       fw_reg_waddr;
    logic [`QLA_DATA_W-1:0]                   fw_reg_wdata;
    logic                                     fw_reg_wen;
    qla_pkg::reg_addr_t                       eth_reg_raddr;
    qla_pkg::reg_addr_t                       eth_reg_waddr;
    logic [`QLA_DATA_W-1:0]                   eth_reg_wdata;
    logic                                     eth_reg_wen;
    logic                                     eth_read_en;
    logic [`QLA_DATA_W-1:0]                   reg_rdata;
    logic [3:0]                               wenid;
    logic [`QLA_NUM_AXES-1:0][`QLA_CUR_W-1:0] cur_fb;
    logic [`QLA_NUM_AXES-1:0][`QLA_CUR_W-1:0] cur_cmd;
    logic [`QLA_NUM_AXES-1:0]                 amp_enable;
    logic                                     pwr_enable;

    // stimulus table, expected column filled by the model
    string       step_name [0:MAX_STEPS-1];
    bit          step_eth  [0:MAX_STEPS-1];
    int          step_op   [0:MAX_STEPS-1];
    logic [15:0] step_addr [0:MAX_STEPS-1];
    logic [31:0] step_data [0:MAX_STEPS-1];
    logic [31:0] step_exp  [0:MAX_STEPS-1];
    int          n_steps     = 0;
    int          cycle_limit = 0;
    int          cycles      = 0;
    int          checks      = 0;
    int          value_errs  = 0;
    int          other_errs  = 0;
    logic [31:0] lfsr        = 32'h1b7b;

    // shadow state of the core
    logic [15:0] m_cmd [0:3];
    logic [15:0] m_fb  [0:3];
    int          m_cnt [0:3];         // consecutive overcurrent edges
    logic [31:0] m_hub [0:15];
    logic [3:0]  m_req   = '0;
    logic [3:0]  m_latch = '0;
    logic        m_pwr   = 1'b0;
    logic        m_clear = 1'b0;      // clear pulse live in this cycle

    qla_reg_core i_qla_reg_core (.*);

    always #50 sysclk = ~sysclk;

    // ------------------------------------------------------------
    // random source
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_random(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w    = {w[30:0], lfsr[0]};   // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // ------------------------------------------------------------
    // reference model
    function automatic logic [31:0] model_read(logic [15:0] a);
        logic [31:0] w;
        w = '0;
        if (a[15:12] == `QLA_ADDR_HUB) begin
            w = m_hub[a[3:0]];
        end else if (a[15:12] == `QLA_ADDR_MAIN && a[7:4] == 4'd0) begin
            if (a[3:0] == `QLA_OFF_STATUS) begin
                w[`QLA_STAT_AMP_EN_LSB +: 4] = m_req;
                w[`QLA_STAT_SAFE_LSB +: 4]   = m_latch;
                w[`QLA_STAT_PWR_BIT]         = m_pwr;
                w[`QLA_STAT_ID_LSB +: 4]     = ~WENID_VAL;
            end
        end else if (a[15:12] == `QLA_ADDR_MAIN && a[7:4] >= 4'd1 && a[7:4] <= 4'd4) begin
            if (a[3:0] == `QLA_OFF_ADC_DATA)
                w = 32'(m_fb[a[7:4] - 4'd1]);
            else if (a[3:0] == `QLA_OFF_DAC_CTRL)
                w = 32'(m_cmd[a[7:4] - 4'd1]);
        end
        return w;
    endfunction

    function automatic logic [31:0] model_outputs(logic [3:0] ch);
        return {m_cmd[ch - 4'd1], 11'b0, m_pwr, m_req & {4{m_pwr}} & ~m_latch};
    endfunction

    // one rising edge, safety uses the command before this write
    task automatic model_edge(bit wr, logic [15:0] a, logic [31:0] d);
        logic [17:0] th;
        for (int i = 0; i < 4; i++) begin
            th = 18'(m_cmd[i]) * 18'd2 + 18'(`QLA_SAFETY_MARGIN);
            if (m_clear) begin
                m_cnt[i]   = 0;
                m_latch[i] = 1'b0;
            end else if (18'(m_fb[i]) > th) begin
                if (m_cnt[i] < `QLA_SAFETY_COUNT)
                    m_cnt[i]++;
                if (m_cnt[i] == `QLA_SAFETY_COUNT)
                    m_latch[i] = 1'b1;
            end else begin
                m_cnt[i] = 0;
            end
        end
        m_clear = 1'b0;
        if (wr && a[15:12] == `QLA_ADDR_HUB) begin
            m_hub[a[3:0]] = d;
        end else if (wr && a[15:12] == `QLA_ADDR_MAIN && a[7:4] == 4'd0
                     && a[3:0] == `QLA_OFF_STATUS) begin
            m_req   = d[`QLA_STAT_AMP_EN_LSB +: 4];
            m_pwr   = d[`QLA_STAT_PWR_BIT];
            m_clear = d[`QLA_STAT_CLEAR_BIT];    // pulse lands next cycle
        end else if (wr && a[15:12] == `QLA_ADDR_MAIN && a[7:4] >= 4'd1 && a[7:4] <= 4'd4
                     && a[3:0] == `QLA_OFF_DAC_CTRL) begin
            m_cmd[a[7:4] - 4'd1] = d[15:0];
        end
    endtask

    task automatic add_step(string name, bit is_eth, int op, logic [15:0] a, logic [31:0] d);
        if (op == OP_FB)
            m_fb[a[7:4] - 4'd1] = d[15:0];
        step_name[n_steps] = name;
        step_eth[n_steps]  = is_eth;
        step_op[n_steps]   = op;
        step_addr[n_steps] = a;
        step_data[n_steps] = d;
        step_exp[n_steps]  = (op == OP_RD) ? model_read(a) :
                             (op == OP_CHK) ? model_outputs(a[7:4]) : 32'h0;
        model_edge(op == OP_WR, a, d);
        n_steps++;
    endtask

    // ------------------------------------------------------------
    task automatic build_table();
        logic [31:0] w;
        logic [15:0] cmd_val [0:3];
        logic [15:0] fb_val  [0:3];
        cmd_val = '{16'h1200, 16'h0400, 16'h2345, 16'h0800};
        fb_val  = '{16'h1000, 16'h0500, 16'h3000, 16'h0900};   // all below threshold
        add_step("reset outputs", 1'b0, OP_CHK, 16'h0010, 0);
        for (int i = 0; i < 4; i++)
            add_step($sformatf("fw cmd write ax%0d", i + 1), 1'b0, OP_WR,
                     {`QLA_ADDR_MAIN, 4'h0, 4'(i + 1), `QLA_OFF_DAC_CTRL}, 32'(cmd_val[i]));
        for (int i = 0; i < 4; i++)
            add_step($sformatf("cmd out ax%0d", i + 1), 1'b0, OP_CHK, {8'h00, 4'(i + 1), 4'h0}, 0);
        for (int i = 0; i < 4; i++)
            add_step($sformatf("fw cmd read ax%0d", i + 1), 1'b0, OP_RD,
                     {`QLA_ADDR_MAIN, 4'h0, 4'(i + 1), `QLA_OFF_DAC_CTRL}, 0);
        for (int i = 0; i < 4; i++)
            add_step($sformatf("set fb ax%0d", i + 1), 1'b0, OP_FB, {8'h00, 4'(i + 1), 4'h0},
                     32'(fb_val[i]));
        for (int i = 0; i < 4; i++)
            add_step($sformatf("fb read ax%0d", i + 1), 1'b0, OP_RD,
                     {`QLA_ADDR_MAIN, 4'h0, 4'(i + 1), `QLA_OFF_ADC_DATA}, 0);
        // eth priority, fw lines carry decoys
        add_step("eth write over fw", 1'b1, OP_WR, 16'h0021, 32'h0000_0600);
        add_step("eth cmd out ax2", 1'b0, OP_CHK, 16'h0020, 0);
        add_step("eth cmd readback", 1'b0, OP_RD, 16'h0021, 0);
        add_step("eth read select", 1'b1, OP_RD, 16'h0011, 0);
        add_step("fw read select", 1'b0, OP_RD, 16'h0010, 0);
        // status register
        add_step("status id", 1'b0, OP_RD, 16'h0000, 0);
        add_step("pwr + amp 1,3", 1'b0, OP_WR, 16'h0000, 32'h0000_0105);
        add_step("amp out 1,3", 1'b0, OP_CHK, 16'h0010, 0);
        add_step("status after enable", 1'b0, OP_RD, 16'h0000, 0);
        add_step("pwr + all amps", 1'b1, OP_WR, 16'h0000, 32'h0000_010f);
        add_step("amp out all", 1'b0, OP_CHK, 16'h0010, 0);
        add_step("pwr off", 1'b0, OP_WR, 16'h0000, 32'h0000_000f);
        add_step("amp out pwr off", 1'b0, OP_CHK, 16'h0010, 0);
        add_step("pwr back on", 1'b0, OP_WR, 16'h0000, 32'h0000_010f);
        // axis 2 trip, threshold 0x0d00
        add_step("overcurrent ax2", 1'b0, OP_FB, 16'h0020, 32'h0000_0e00);
        for (int i = 0; i < 3; i++)
            add_step("trip wait", 1'b0, OP_IDLE, 16'h0000, 0);
        add_step("amp out after trip", 1'b0, OP_CHK, 16'h0020, 0);
        add_step("status latch ax2", 1'b0, OP_RD, 16'h0000, 0);
        add_step("fb ax2 normal", 1'b0, OP_FB, 16'h0020, 32'h0000_0500);
        add_step("clear latches", 1'b0, OP_WR, 16'h0000, 32'h0000_030f);
        add_step("amp out clear pulse", 1'b0, OP_CHK, 16'h0020, 0);
        add_step("amp out cleared", 1'b0, OP_CHK, 16'h0020, 0);
        add_step("status cleared", 1'b0, OP_RD, 16'h0000, 0);
        // three cycles over on axis 3, no trip
        add_step("dip ax3 high", 1'b0, OP_FB, 16'h0030, 32'h0000_5000);
        add_step("dip wait", 1'b0, OP_IDLE, 16'h0000, 0);
        add_step("dip wait", 1'b0, OP_IDLE, 16'h0000, 0);
        add_step("dip ax3 low", 1'b0, OP_FB, 16'h0030, 32'h0000_3000);
        add_step("amp out after dip", 1'b0, OP_CHK, 16'h0030, 0);
        add_step("status after dip", 1'b0, OP_RD, 16'h0000, 0);
        // hub scratch, both masters
        for (int i = 0; i < 16; i++) begin
            take_random(w);
            add_step($sformatf("hub write %0d", i), i[0], OP_WR, {`QLA_ADDR_HUB, 12'(i)}, w);
        end
        for (int i = 0; i < 16; i++)
            add_step($sformatf("hub read %0d", i), ~i[0], OP_RD, {`QLA_ADDR_HUB, 12'(i)}, 0);
        // unmapped
        add_step("unmapped space", 1'b0, OP_RD, 16'h1010, 0);
        add_step("unmapped chan 5", 1'b0, OP_RD, 16'h0051, 0);
        add_step("unused axis offset", 1'b1, OP_RD, 16'h0012, 0);
    endtask

    task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        chk_value: assert (act === exp) else begin
            $display("FAILED %s: expected %08h, actual %08h", name, exp, act);
            value_errs++;
        end
    endtask

    // ------------------------------------------------------------
    initial begin : main_seq
        logic [15:0] a;
        logic [31:0] d;
        int          idx;
        rst_n         = 1'b0;
        fw_reg_raddr  = '0;
        fw_reg_waddr  = '0;
        fw_reg_wdata  = '0;
        fw_reg_wen    = 1'b0;
        eth_reg_raddr = '0;
        eth_reg_waddr = '0;
        eth_reg_wdata = '0;
        eth_reg_wen   = 1'b0;
        eth_read_en   = 1'b0;
        wenid         = WENID_VAL;
        cur_fb        = '0;
        for (int i = 0; i < 4; i++) begin
            m_cmd[i] = '0;
            m_fb[i]  = '0;
            m_cnt[i] = 0;
        end
        build_table();
        cycle_limit = n_steps + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge sysclk);
        #5;
        rst_n = 1'b1;
        for (int k = 0; k < n_steps; k++) begin
            @(posedge sysclk);
            #5;
            a           = step_addr[k];
            d           = step_data[k];
            idx         = int'(a[7:4]) - 1;
            fw_reg_wen  = 1'b0;
            eth_reg_wen = 1'b0;
            eth_read_en = 1'b0;
            case (step_op[k])
                OP_WR: begin
                    if (step_eth[k]) begin
                        eth_reg_waddr = a;
                        eth_reg_wdata = d;
                        eth_reg_wen   = 1'b1;
                        fw_reg_waddr  = a ^ 16'h0001;   // decoy, strobe stays low
                        fw_reg_wdata  = ~d;
                    end else begin
                        fw_reg_waddr  = a;
                        fw_reg_wdata  = d;
                        fw_reg_wen    = 1'b1;
                        eth_reg_waddr = a ^ 16'h0001;
                        eth_reg_wdata = ~d;
                    end
                end
                OP_RD: begin
                    eth_read_en   = step_eth[k];
                    eth_reg_raddr = step_eth[k] ? a : (a ^ 16'h0001);
                    fw_reg_raddr  = step_eth[k] ? (a ^ 16'h0001) : a;
                end
                OP_FB: cur_fb[idx] = d[15:0];
                default: ;
            endcase
            #90;   // just before the next edge
            if (step_op[k] == OP_RD)
                check_word(step_name[k], step_exp[k], reg_rdata);
            else if (step_op[k] == OP_CHK)
                check_word(step_name[k], step_exp[k],
                           {cur_cmd[idx], 11'b0, pwr_enable, amp_enable});
        end
        $display("checks: %0d  value errors: %0d  other errors: %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog, limit known once the table is built
    initial begin : watchdog
        @(posedge sysclk);
        while (cycles < cycle_limit) begin
            @(posedge sysclk);
            cycles++;
        end
        other_errs++;
        $display("timeout: the test sequence did not finish within %0d cycles", cycle_limit);
        $display("checks: %0d  value errors: %0d  other errors: %0d",
                 checks, value_errs, other_errs);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- src/qla_reg_core.sv
`timescale 1ns/1ps
`include "qla_consts.svh"

module qla_reg_core (
    input  logic                                     sysclk,
    input  logic                                     rst_n,
    // firewire master
    input  qla_pkg::reg_addr_t                       fw_reg_raddr,
    input  qla_pkg::reg_addr_t                       fw_reg_waddr,
    input  logic [`QLA_DATA_W-1:0]                   fw_reg_wdata,
    input  logic                                     fw_reg_wen,
    // ethernet master
    input  qla_pkg::reg_addr_t                       eth_reg_raddr,
    input  qla_pkg::reg_addr_t                       eth_reg_waddr,
    input  logic [`QLA_DATA_W-1:0]                   eth_reg_wdata,
    input  logic                                     eth_reg_wen,
    input  logic                                     eth_read_en,
    output logic [`QLA_DATA_W-1:0]                   reg_rdata,   // seen by both
    // board side
    input  logic [3:0]                               wenid,
    input  logic [`QLA_NUM_AXES-1:0][`QLA_CUR_W-1:0] cur_fb,
    output logic [`QLA_NUM_AXES-1:0][`QLA_CUR_W-1:0] cur_cmd,
    output logic [`QLA_NUM_AXES-1:0]                 amp_enable,
    output logic                                     pwr_enable
);

    qla_pkg::reg_addr_t       reg_raddr;
    qla_pkg::reg_addr_t       reg_waddr;
    logic [`QLA_DATA_W-1:0]   reg_wdata;
    logic                     reg_wen;
    logic [`QLA_DATA_W-1:0]   hub_rdata;
    logic [`QLA_DATA_W-1:0]   chan0_rdata;
    logic [`QLA_DATA_W-1:0]   axis_rdata;
    logic [`QLA_NUM_AXES-1:0] safety_disable;
    logic                     safety_clear;

    // ----------------------------------------------------------
    // master merge
    reg_bus_merge i_reg_bus_merge (
        .sysclk        (sysclk),
        .rst_n         (rst_n),
        .fw_reg_raddr  (fw_reg_raddr),
        .fw_reg_waddr  (fw_reg_waddr),
        .fw_reg_wdata  (fw_reg_wdata),
        .fw_reg_wen    (fw_reg_wen),
        .eth_reg_raddr (eth_reg_raddr),
        .eth_reg_waddr (eth_reg_waddr),
        .eth_reg_wdata (eth_reg_wdata),
        .eth_reg_wen   (eth_reg_wen),
        .eth_read_en   (eth_read_en),
        .reg_raddr     (reg_raddr),
        .reg_waddr     (reg_waddr),
        .reg_wdata     (reg_wdata),
        .reg_wen       (reg_wen)
    );

    hub_scratch i_hub_scratch (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_raddr (reg_raddr),
        .reg_wdata (reg_wdata),
        .hub_rdata (hub_rdata)
    );

    axis_cmd_regs i_axis_cmd_regs (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .reg_wen    (reg_wen),
        .reg_waddr  (reg_waddr),
        .reg_raddr  (reg_raddr),
        .reg_wdata  (reg_wdata),
        .cur_fb     (cur_fb),
        .cur_cmd    (cur_cmd),
        .axis_rdata (axis_rdata)
    );

    // overcurrent check on every axis
    safety_check i_safety_check (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .cur_fb         (cur_fb),
        .cur_cmd        (cur_cmd),
        .safety_clear   (safety_clear),
        .safety_disable (safety_disable)
    );

    board_regs i_board_regs (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .reg_wen        (reg_wen),
        .reg_waddr      (reg_waddr),
        .reg_raddr      (reg_raddr),
        .reg_wdata      (reg_wdata),
        .wenid          (wenid),
        .safety_disable (safety_disable),
        .safety_clear   (safety_clear),
        .amp_enable     (amp_enable),
        .pwr_enable     (pwr_enable),
        .chan0_rdata    (chan0_rdata)
    );

    reg_read_router i_reg_read_router (
        .reg_raddr   (reg_raddr),
        .hub_rdata   (hub_rdata),
        .chan0_rdata (chan0_rdata),
        .axis_rdata  (axis_rdata),
        .reg_rdata   (reg_rdata)
    );

endmodule

//--- src/reg_read_router.sv
`timescale 1ns/1ps
`include "qla_consts.svh"

module reg_read_router (
    input  qla_pkg::reg_addr_t      reg_raddr,
    input  logic [`QLA_DATA_W-1:0]  hub_rdata,
    input  logic [`QLA_DATA_W-1:0]  chan0_rdata,
    input  logic [`QLA_DATA_W-1:0]  axis_rdata,
    output logic [`QLA_DATA_W-1:0]  reg_rdata
);

    // decode by space first, then channel
    always_comb begin
        reg_rdata = '0;   // unmapped reads as zero
        case (reg_raddr.main.space)
            `QLA_ADDR_HUB: begin
                reg_rdata = hub_rdata;
            end
            `QLA_ADDR_MAIN: begin
                if (reg_raddr.main.chan == 4'd0)
                    reg_rdata = chan0_rdata;                       // board regs
                else if (reg_raddr.main.chan <= 4'(`QLA_NUM_AXES))
                    reg_rdata = axis_rdata;                        // axes 1..4
            end
            default: begin
                reg_rdata = '0;
            end
        endcase
    end

endmodule

//--- src/board_regs.sv
`timescale 1ns/1ps
`include "qla_consts.svh"

module board_regs (
    input  logic                     sysclk,
    input  logic                     rst_n,
    input  logic                     reg_wen,
    input  qla_pkg::reg_addr_t       reg_waddr,
    input  qla_pkg::reg_addr_t       reg_raddr,
    input  logic [`QLA_DATA_W-1:0]   reg_wdata,
    input  logic [3:0]               wenid,           // rotary switch, inverted id
    input  logic [`QLA_NUM_AXES-1:0] safety_disable,
    output logic                     safety_clear,    // one cycle pulse
    output logic [`QLA_NUM_AXES-1:0] amp_enable,
    output logic                     pwr_enable,
    output logic [`QLA_DATA_W-1:0]   chan0_rdata
);

    logic [`QLA_NUM_AXES-1:0] amp_req;   // host enable requests
    logic                     stat_wr;

    assign stat_wr = reg_wen
                  && (reg_waddr.main.space  == `QLA_ADDR_MAIN)
                  && (reg_waddr.main.chan   == 4'd0)
                  && (reg_waddr.main.offset == `QLA_OFF_STATUS);

    // ----------------------------------------------------------
    // status write
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            amp_req      <= '0;
            pwr_enable   <= 1'b0;
            safety_clear <= 1'b0;
        end else begin
            safety_clear <= stat_wr && reg_wdata[`QLA_STAT_CLEAR_BIT];
            if (stat_wr) begin
                amp_req    <= reg_wdata[`QLA_STAT_AMP_EN_LSB +: `QLA_NUM_AXES];
                pwr_enable <= reg_wdata[`QLA_STAT_PWR_BIT];
            end
        end
    end

    // latch drops the amp right away, no extra edge
    assign amp_enable = amp_req & {`QLA_NUM_AXES{pwr_enable}} & ~safety_disable;

    // ----------------------------------------------------------
    // status readback, clear bit reads as zero
    always_comb begin
        chan0_rdata = '0;
        if (reg_raddr.main.offset == `QLA_OFF_STATUS) begin
            chan0_rdata[`QLA_STAT_AMP_EN_LSB +: `QLA_NUM_AXES] = amp_req;
            chan0_rdata[`QLA_STAT_SAFE_LSB +: `QLA_NUM_AXES]   = safety_disable;
            chan0_rdata[`QLA_STAT_PWR_BIT]                     = pwr_enable;
            chan0_rdata[`QLA_STAT_ID_LSB +: 4]                 = ~wenid;  // board id
        end
    end

endmodule

//--- src/safety_check.sv
`timescale 1ns/1ps
`include "qla_consts.svh"

module safety_check (
    input  logic                                     sysclk,
    input  logic                                     rst_n,
    input  logic [`QLA_NUM_AXES-1:0][`QLA_CUR_W-1:0] cur_fb,
    input  logic [`QLA_NUM_AXES-1:0][`QLA_CUR_W-1:0] cur_cmd,
    input  logic                                     safety_clear,
    output logic [`QLA_NUM_AXES-1:0]                 safety_disable  // latched trips
);

    localparam int TH_W  = `QLA_CUR_W + 2;              // 2*cmd + margin headroom
    localparam int CNT_W = $clog2(`QLA_SAFETY_COUNT + 1);

    logic [`QLA_NUM_AXES-1:0][TH_W-1:0]  thresh;
    logic [`QLA_NUM_AXES-1:0]            over;
    logic [`QLA_NUM_AXES-1:0][CNT_W-1:0] over_cnt;     // consecutive hits

    // fb > 2*cmd + margin, unsigned
    always_comb begin
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            thresh[i] = {1'b0, cur_cmd[i], 1'b0} + TH_W'(`QLA_SAFETY_MARGIN);
            over[i]   = {2'b00, cur_fb[i]} > thresh[i];
        end
    end

    // ----------------------------------------------------------
    // counters and latches
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            over_cnt       <= '0;
            safety_disable <= '0;
        end else if (safety_clear) begin
            over_cnt       <= '0;   // clear wins over a fresh trip
            safety_disable <= '0;
        end else begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (!over[i]) begin
                    over_cnt[i] <= '0;                       // streak broken
                end else if (over_cnt[i] != CNT_W'(`QLA_SAFETY_COUNT)) begin
                    over_cnt[i] <= over_cnt[i] + 1'b1;
                    if (over_cnt[i] == CNT_W'(`QLA_SAFETY_COUNT - 1))
                        safety_disable[i] <= 1'b1;           // trip on last hit
                end
            end
        end
    end

    a_no_set_on_clear: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        (safety_disable & ~$past(safety_disable)) != '0 |-> !$past(safety_clear)
    ) else $error("safety latch set during clear");

endmodule

//--- src/axis_cmd_regs.sv
`timescale 1ns/1ps
`include "qla_consts.svh"

module axis_cmd_regs (
    input  logic                                     sysclk,
    input  logic                                     rst_n,
    input  logic                                     reg_wen,
    input  qla_pkg::reg_addr_t                       reg_waddr,
    input  qla_pkg::reg_addr_t                       reg_raddr,
    input  logic [`QLA_DATA_W-1:0]                   reg_wdata,
    input  logic [`QLA_NUM_AXES-1:0][`QLA_CUR_W-1:0] cur_fb,    // axis 1 in [0]
    output logic [`QLA_NUM_AXES-1:0][`QLA_CUR_W-1:0] cur_cmd,
    output logic [`QLA_DATA_W-1:0]                   axis_rdata
);

    logic cmd_wr;   // dac ctrl write, any channel

    assign cmd_wr = reg_wen
                 && (reg_waddr.main.space  == `QLA_ADDR_MAIN)
                 && (reg_waddr.main.offset == `QLA_OFF_DAC_CTRL);

    // command regs, chan n maps to axis n-1
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cur_cmd <= '0;
        end else if (cmd_wr) begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (reg_waddr.main.chan == 4'(i + 1))
                    cur_cmd[i] <= reg_wdata[`QLA_CUR_W-1:0];   // low half only
            end
        end
    end

    // readback, zero extended
    always_comb begin
        axis_rdata = '0;
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            if (reg_raddr.main.chan == 4'(i + 1)) begin
                if (reg_raddr.main.offset == `QLA_OFF_ADC_DATA)
                    axis_rdata = {{(`QLA_DATA_W-`QLA_CUR_W){1'b0}}, cur_fb[i]};
                else if (reg_raddr.main.offset == `QLA_OFF_DAC_CTRL)
                    axis_rdata = {{(`QLA_DATA_W-`QLA_CUR_W){1'b0}}, cur_cmd[i]};
            end
        end
    end

    // a command write outside chans 1..4 would vanish silently
    a_cmd_chan_range: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        cmd_wr |-> (reg_waddr.main.chan != 4'd0)
                && (reg_waddr.main.chan <= 4'(`QLA_NUM_AXES))
    ) else $error("command write to chan %0d", reg_waddr.main.chan);

endmodule

//--- src/hub_scratch.sv
`timescale 1ns/1ps
`include "qla_consts.svh"

module hub_scratch (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  logic                    reg_wen,
    input  qla_pkg::reg_addr_t      reg_waddr,
    input  qla_pkg::reg_addr_t      reg_raddr,
    input  logic [`QLA_DATA_W-1:0]  reg_wdata,
    output logic [`QLA_DATA_W-1:0]  hub_rdata
);

    localparam int DEPTH = 16;

    logic [`QLA_DATA_W-1:0] mem [0:DEPTH-1];   // scratch words
    logic                   hub_wr;
    logic [3:0]             widx;
    logic [3:0]             ridx;

    // only the low nibble of the hub index selects a word
    assign widx   = reg_waddr.hub.index[3:0];
    assign ridx   = reg_raddr.hub.index[3:0];
    assign hub_wr = reg_wen && (reg_waddr.hub.space == `QLA_ADDR_HUB);

    // single edge write, ignored while held in reset
    always_ff @(posedge sysclk) begin
        if (rst_n && hub_wr) begin
            mem[widx] <= reg_wdata;
        end
    end

    // always presented, router picks it up for hub space only
    assign hub_rdata = mem[ridx];

endmodule

//--- src/reg_bus_merge.sv
`timescale 1ns/1ps
`include "qla_consts.svh"

module reg_bus_merge (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  qla_pkg::reg_addr_t      fw_reg_raddr,
    input  qla_pkg::reg_addr_t      fw_reg_waddr,
    input  logic [`QLA_DATA_W-1:0]  fw_reg_wdata,
    input  logic                    fw_reg_wen,
    input  qla_pkg::reg_addr_t      eth_reg_raddr,
    input  qla_pkg::reg_addr_t      eth_reg_waddr,
    input  logic [`QLA_DATA_W-1:0]  eth_reg_wdata,
    input  logic                    eth_reg_wen,
    input  logic                    eth_read_en,   // eth owns the read address
    output qla_pkg::reg_addr_t      reg_raddr,
    output qla_pkg::reg_addr_t      reg_waddr,
    output logic [`QLA_DATA_W-1:0]  reg_wdata,
    output logic                    reg_wen
);

    // ethernet wins the write path while its strobe is up
    assign reg_waddr = eth_reg_wen ? eth_reg_waddr : fw_reg_waddr;
    assign reg_wdata = eth_reg_wen ? eth_reg_wdata : fw_reg_wdata;
    assign reg_wen   = fw_reg_wen | eth_reg_wen;

    // read side follows the ethernet select
    assign reg_raddr = eth_read_en ? eth_reg_raddr : fw_reg_raddr;

    // ----------------------------------------------------------
    // masters must take turns, a collision would drop the fw write
    a_no_dual_wen: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        !(fw_reg_wen && eth_reg_wen)
    ) else $error("fw and eth write strobes collided");

endmodule

//--- src/qla_pkg.sv
`include "qla_consts.svh"

package qla_pkg;

    // one register address word, two decodings
    //   main: space | unused | chan | offset
    //   hub:  space | index
    typedef union packed {
        struct packed {
            logic [3:0] space;
            logic [3:0] unused;
            logic [3:0] chan;          // 0 = board, 1..4 = axes
            logic [3:0] offset;
        } main;
        struct packed {
            logic [3:0]               space;
            logic [`QLA_ADDR_W-5:0]   index;   // hub word index
        } hub;
    } reg_addr_t;

endpackage

//--- src/qla_consts.svh
`ifndef QLA_CONSTS_SVH
`define QLA_CONSTS_SVH

// bus widths
`define QLA_ADDR_W          16
`define QLA_DATA_W          32
`define QLA_CUR_W           16          // adc / dac current word
`define QLA_NUM_AXES        4

// address spaces, addr[15:12]
`define QLA_ADDR_MAIN       4'h0
`define QLA_ADDR_HUB        4'h2

// offsets within a channel, addr[3:0]
`define QLA_OFF_ADC_DATA    4'h0        // feedback readback, axis chans
`define QLA_OFF_DAC_CTRL    4'h1        // current command, axis chans
`define QLA_OFF_STATUS      4'h0        // board status, chan 0

// status register layout
`define QLA_STAT_AMP_EN_LSB 0           // amp enable requests 3:0
`define QLA_STAT_SAFE_LSB   4           // safety latches 7:4, read only
`define QLA_STAT_PWR_BIT    8
`define QLA_STAT_CLEAR_BIT  9           // write 1 clears latches
`define QLA_STAT_ID_LSB     24          // board id 27:24

// overcurrent detection
`define QLA_SAFETY_MARGIN   16'h0100
`define QLA_SAFETY_COUNT    4

`endif
